// File: rtl/cachePkg.sv
package cachePkg;

   // the cache serves a 16-bit byte address space
   localparam int addrBits = 16;

   // each cached word is 16 bits wide
   localparam int dataBits = 16;

   // an address splits into tag, set and offset, from the top down
   localparam int tagBits = 6;
   localparam int setBits = 6;
   localparam int offsetBits = 4;

   // a block of 16 bytes holds eight 16-bit words
   localparam int wordsPerBlock = 8;

   // the word index is the offset without its byte bit
   localparam int wordIdxBits = 3;

   // six set bits give 64 sets, each with two ways
   localparam int numSets = 64;

   // one metadata entry per way per set
   // the LRU bit is kept apart, since there is one per set and not per way
   typedef struct packed {
      logic               valid;
      logic [tagBits-1:0] tag;
   } metaT;

endpackage

// File: rtl/axiPkg.sv
package axiPkg;

   // AXI response codes as they appear on rresp
   typedef enum logic [1:0] {
      respOkay   = 2'b00,
      respExOkay = 2'b01,
      respSlvErr = 2'b10,
      respDecErr = 2'b11
   } respT;

   // fill sequence for one missing block
   // request drives one read address, collect waits for its data beat,
   // commit writes the tag and valid bit once all eight words are in
   typedef enum logic [1:0] {
      fillIdle    = 2'b00,
      fillRequest = 2'b01,
      fillCollect = 2'b10,
      fillCommit  = 2'b11
   } fillStateT;

endpackage

// File: rtl/fillIf.sv
`timescale 1ns/1ps

interface fillIf import cachePkg::*; ();

   // way that is being refilled, held for the whole fill
   logic                   fillWay;
   // word slot within the block for the current data write
   logic [wordIdxBits-1:0] wordIdx;
   logic [dataBits-1:0]    fillData;
   // one data word is written on each clock where this is high
   logic                   dataWr;
   // metadata and LRU are written on the single commit clock
   logic                   metaWr;
   logic [setBits-1:0]     fillSet;
   metaT                   fillMeta;
   // way the arrays would evict for the address now presented
   logic                   missWay;

   // the fill controller owns the write side
   modport controller (
      output fillWay, wordIdx, fillData, dataWr, metaWr, fillSet, fillMeta,
      input  missWay
   );

   // the arrays take the writes and offer their victim way
   modport arrays (
      input  fillWay, wordIdx, fillData, dataWr, metaWr, fillSet, fillMeta,
      output missWay
   );

endinterface

// File: rtl/beatCounter.sv
`timescale 1ns/1ps

module beatCounter import cachePkg::*; (
   input  logic                 clk,
   input  logic                 rstN,
   input  logic                 start,
   input  logic                 arFire,
   input  logic                 rFire,
   output logic [wordIdxBits:0] arCount,
   output logic [wordIdxBits:0] rCount,
   output logic                 lastBeat
);

   // one extra bit so that a full block of eight beats can be counted
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         arCount <= '0;
         rCount <= '0;
      end else if (start) begin
         arCount <= '0;
         rCount <= '0;
      end else begin
         if (arFire) begin
            arCount <= arCount + 1'b1;
         end
         if (rFire) begin
            rCount <= rCount + 1'b1;
         end
      end
   end

   // all data beats of the block have been taken in
   assign lastBeat = (rCount == (wordIdxBits + 1)'(wordsPerBlock));

endmodule

// File: rtl/cacheArrays.sv
`timescale 1ns/1ps

module cacheArrays import cachePkg::*; (
   input  logic                clk,
   input  logic                rstN,
   input  logic [addrBits-1:0] addr,
   input  logic                lookup,
   output logic                hit,
   output logic [dataBits-1:0] hitData,
   fillIf.arrays               fill
);

   // address fields of the current request
   logic [tagBits-1:0]     tag;
   logic [setBits-1:0]     setIdx;
   logic [wordIdxBits-1:0] wordSel;

   // metadata per way and set, only the valid bits see reset
   metaT metaArr [2][numSets];

   // block storage, indexed by way, set and word
   logic [dataBits-1:0] dataArr [2][numSets][wordsPerBlock];

   // one bit per set naming the way to evict next
   logic [numSets-1:0] lru;

   // entries of the addressed set
   metaT meta0;
   metaT meta1;

   logic match0;
   logic match1;
   logic hitWay;

   // tag sits at the top, set right above the offset
   assign tag = addr[addrBits-1 -: tagBits];
   assign setIdx = addr[offsetBits +: setBits];

   // bit 0 of the offset picks a byte, so it plays no part in word selection
   assign wordSel = addr[offsetBits-1:1];

   // both ways of the set are read combinationally
   assign meta0 = metaArr[0][setIdx];
   assign meta1 = metaArr[1][setIdx];

   // a way matches when its entry is valid and its tag agrees
   assign match0 = meta0.valid && (meta0.tag == tag);
   assign match1 = meta1.valid && (meta1.tag == tag);

   assign hit = match0 || match1;

   // way 0 wins when it matches, otherwise the hit (if any) is in way 1
   assign hitWay = !match0;

   // read data goes out in the same cycle as the request
   assign hitData = dataArr[hitWay][setIdx][wordSel];

   // on a miss the LRU bit of the set names the victim
   assign fill.missWay = lru[setIdx];

   // the fill writes one entry once all words of the block are in place
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int s = 0; s < numSets; s++) begin
            metaArr[0][s].valid <= 1'b0;
            metaArr[1][s].valid <= 1'b0;
         end
      end else if (fill.metaWr) begin
         metaArr[fill.fillWay][fill.fillSet] <= fill.fillMeta;
      end
   end

   // the LRU bit always ends up naming the way that was not used last
   // a commit and a looked-up hit never share a clock, since lookup
   // is only high while the fill controller sits idle
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         lru <= '0;
      end else if (fill.metaWr) begin
         lru[fill.fillSet] <= ~fill.fillWay;
      end else if (lookup && hit) begin
         lru[setIdx] <= ~hitWay;
      end
   end

   // data words arrive one per beat from the fill
   always_ff @(posedge clk) begin
      if (fill.dataWr) begin
         dataArr[fill.fillWay][fill.fillSet][fill.wordIdx] <= fill.fillData;
      end
   end

endmodule

// File: rtl/fillController.sv
`timescale 1ns/1ps

module fillController import cachePkg::*, axiPkg::*; (
   input  logic                clk,
   input  logic                rstN,
   input  logic [addrBits-1:0] addr,
   input  logic                miss,
   output logic [addrBits-1:0] araddr,
   output logic                arvalid,
   input  logic                arready,
   input  logic [dataBits-1:0] memData,
   input  logic                rvalid,
   output logic                rready,
   output logic                idle,
   fillIf.controller           fill
);

   fillStateT state;
   fillStateT stateNext;

   // tag and set of the block being fetched
   logic [addrBits-offsetBits-1:0] blockBase;
   logic                           wayQ;

   logic                 start;
   logic                 arFire;
   logic                 rFire;
   logic [wordIdxBits:0] arCount;
   logic [wordIdxBits:0] rCount;
   logic                 lastBeat;

   assign idle = (state == fillIdle);
   assign start = idle && miss;

   // one address at a time, so at most one read is ever outstanding
   assign arvalid = (state == fillRequest);
   // rready drops once the last beat is counted so no extra word is taken
   assign rready = (state == fillCollect) && !lastBeat;

   assign arFire = arvalid && arready;
   assign rFire = rvalid && rready;

   // word address of the current beat, steady while waiting for arready
   assign araddr = {blockBase, arCount[wordIdxBits-1:0], 1'b0};

   beatCounter beatCounter_inst (
      .clk      (clk),
      .rstN     (rstN),
      .start    (start),
      .arFire   (arFire),
      .rFire    (rFire),
      .arCount  (arCount),
      .rCount   (rCount),
      .lastBeat (lastBeat)
   );

   always_comb begin
      stateNext = state;
      unique case (state)
         fillIdle: begin
            if (miss) begin
               stateNext = fillRequest;
            end
         end
         fillRequest: begin
            if (arFire) begin
               stateNext = fillCollect;
            end
         end
         fillCollect: begin
            // after the eighth beat, wait here one clock for the count to settle
            if (lastBeat) begin
               stateNext = fillCommit;
            end else if (rFire && (arCount != (wordIdxBits + 1)'(wordsPerBlock))) begin
               stateNext = fillRequest;
            end
         end
         fillCommit: begin
            stateNext = fillIdle;
         end
         default: begin
            stateNext = fillIdle;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state <= fillIdle;
         wayQ <= 1'b0;
      end else begin
         state <= stateNext;
         // the victim is fixed at the miss and kept until the commit
         if (start) begin
            wayQ <= fill.missWay;
         end
      end
   end

   // address is held by the requester until ready, so a plain capture works
   always_ff @(posedge clk) begin
      if (start) begin
         blockBase <= addr[addrBits-1:offsetBits];
      end
   end

   // each accepted data beat goes straight into the arrays
   assign fill.fillWay = wayQ;
   assign fill.wordIdx = rCount[wordIdxBits-1:0];
   assign fill.fillData = memData;
   assign fill.dataWr = rFire;

   // the commit clock makes the new block visible to lookups
   assign fill.metaWr = (state == fillCommit);
   assign fill.fillSet = blockBase[setBits-1:0];
   assign fill.fillMeta = '{valid: 1'b1, tag: blockBase[setBits +: tagBits]};

endmodule

// File: rtl/cacheTop.sv
`timescale 1ns/1ps

module cacheTop import cachePkg::*, axiPkg::*; (
   input  logic                clk,
   input  logic                rstN,
   // CPU side, req and addr stay put until ready
   input  logic                req,
   input  logic [addrBits-1:0] addr,
   output logic                ready,
   output logic [dataBits-1:0] rdata,
   // AXI4-Lite read address channel
   output logic [addrBits-1:0] araddr,
   output logic [2:0]          arprot,
   output logic                arvalid,
   input  logic                arready,
   // AXI4-Lite read data channel
   input  logic [dataBits-1:0] memRdata,
   input  respT                rresp,
   input  logic                rvalid,
   output logic                rready
);

   logic                hit;
   logic                idle;
   logic                lookup;
   logic                miss;
   logic [dataBits-1:0] hitData;

   // carries the fill writes between controller and arrays
   fillIf fillIf_inst ();

   // lookups only count while no fill is running
   assign lookup = req && idle;
   assign ready = lookup && hit;
   assign miss = lookup && !hit;

   // data is only meaningful alongside ready
   assign rdata = ready ? hitData : '0;

   // unprivileged, secure, data access
   assign arprot = 3'b000;

   // rresp arrives with each beat but an error does not change the fill

   cacheArrays cacheArrays_inst (
      .clk     (clk),
      .rstN    (rstN),
      .addr    (addr),
      .lookup  (lookup),
      .hit     (hit),
      .hitData (hitData),
      .fill    (fillIf_inst.arrays)
   );

   fillController fillController_inst (
      .clk     (clk),
      .rstN    (rstN),
      .addr    (addr),
      .miss    (miss),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .memData (memRdata),
      .rvalid  (rvalid),
      .rready  (rready),
      .idle    (idle),
      .fill    (fillIf_inst.controller)
   );

endmodule

// File: dv/cacheTop_chk.sv
`timescale 1ns/1ps

module cacheTop_chk import cachePkg::*, axiPkg::*; (
   input logic                clk,
   input logic                rstN,
   input logic [addrBits-1:0] araddr,
   input logic                arvalid,
   input logic                arready,
   input logic                rready,
   input logic                ready,
   input fillStateT           fillState
);

   // failures so far, picked up by the testbench at the end of the run
   int failCount = 0;

   // an offered read address stays put until the memory takes it
   arHold: assert property (
      @(posedge clk) disable iff (!rstN)
      arvalid && !arready |=> arvalid && $stable(araddr)
   ) else begin
      $error("read address dropped or changed before arready");
      failCount++;
   end

   // data is only accepted while the fill waits for a beat
   rreadyCollect: assert property (
      @(posedge clk) disable iff (!rstN)
      rready |-> fillState == fillCollect
   ) else begin
      $error("rready high outside the collect state");
      failCount++;
   end

   // the CPU never sees ready while a fill is running
   readyIdle: assert property (
      @(posedge clk) disable iff (!rstN)
      ready |-> fillState == fillIdle
   ) else begin
      $error("ready high while the fill controller is busy");
      failCount++;
   end

   // both AXI outputs come out of reset quiet
   quietAfterReset: assert property (
      @(posedge clk) $rose(rstN) |-> !arvalid && !rready
   ) else begin
      $error("arvalid or rready high in the first cycle after reset");
      failCount++;
   end

endmodule

bind cacheTop cacheTop_chk cacheTopChk_inst (
   .clk       (clk),
   .rstN      (rstN),
   .araddr    (araddr),
   .arvalid   (arvalid),
   .arready   (arready),
   .rready    (rready),
   .ready     (ready),
   .fillState (fillController_inst.state)
);

// File: dv/tbCache.sv
`timescale 1ns/1ps

module tbCache import cachePkg::*, axiPkg::*;;

   localparam logic [31:0] lcgSeed = 32'h78ba;
   // about 40 accesses, each miss taking up to about 100 cycles, plus margin
   localparam int timeoutCycles = 5000;

   logic                clk;
   logic                rstN;
   logic                req;
   logic [addrBits-1:0] addr;
   logic                ready;
   logic [dataBits-1:0] rdata;
   logic [addrBits-1:0] araddr;
   logic [2:0]          arprot;
   logic                arvalid;
   logic                arready = 1'b0;
   logic [dataBits-1:0] memRdata = '0;
   respT                rresp = respOkay;
   logic                rvalid = 1'b0;
   logic                rready;

   // memory responder state, owned by the responder process
   logic [31:0]         delaySeed = lcgSeed;
   int                  arWait = 0;
   int                  rWait = 0;
   logic                arFired = 1'b0;
   logic                rFired = 1'b0;
   logic                readPending = 1'b0;
   logic [addrBits-1:0] firedAddr = '0;
   logic [addrBits-1:0] pendingAddr = '0;
   // read addresses accepted during the current access
   logic [addrBits-1:0] arLog [$];

   logic [31:0]         addrSeed;
   logic [addrBits-1:0] randAddr;
   int                  cycleCount = 0;
   int                  checkCount = 0;
   int                  errorCount = 0;
   int                  testErrors = 0;
   int                  assertFails = 0;
   string               testName;

   cacheTop cacheTop_inst (
      .clk      (clk),
      .rstN     (rstN),
      .req      (req),
      .addr     (addr),
      .ready    (ready),
      .rdata    (rdata),
      .araddr   (araddr),
      .arprot   (arprot),
      .arvalid  (arvalid),
      .arready  (arready),
      .memRdata (memRdata),
      .rresp    (rresp),
      .rvalid   (rvalid),
      .rready   (rready)
   );

   function automatic logic [31:0] lcgStep(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // memory holds the byte address XOR a constant, always at an even value
   function automatic logic [dataBits-1:0] memWord(input logic [addrBits-1:0] a);
      return (a ^ 16'hA5C3) & 16'hFFFE;
   endfunction

   task automatic check(input logic cond, input string msg);
      checkCount++;
      assert (cond) else begin
         errorCount++;
         $display("CHECK FAILED at %0t ns: %s", $time, msg);
      end
   endtask

   task automatic startTest(input string name);
      testName = name;
      testErrors = errorCount;
   endtask

   task automatic endTest();
      if (errorCount == testErrors) begin
         $display("%s: ok", testName);
      end else begin
         $display("%s: %0d checks went wrong", testName, errorCount - testErrors);
      end
   endtask

   // one CPU read, mode 0 expects a hit, 1 a miss and 2 takes either
   task automatic access(input logic [addrBits-1:0] a, input int mode);
      int                  waitCycles;
      logic [addrBits-1:0] base;
      base = {a[addrBits-1:offsetBits], {offsetBits{1'b0}}};
      waitCycles = 0;
      @(negedge clk);
      req = 1'b1;
      addr = a;
      #1;
      arLog.delete();
      while (!ready) begin
         @(negedge clk);
         #1;
         waitCycles++;
      end
      check(rdata == memWord(a),
            $sformatf("read of %h gave %h, expected %h", a, rdata, memWord(a)));
      if (mode == 0) begin
         check(waitCycles == 0, $sformatf("read of %h took %0d cycles", a, waitCycles));
         check(arLog.size() == 0, $sformatf("read of %h went to memory", a));
      end else if (mode == 1) begin
         check(arLog.size() != 0, $sformatf("read of %h hit, a miss was due", a));
      end
      // a fill walks the whole block one word at a time
      if (arLog.size() != 0) begin
         check(arLog.size() == wordsPerBlock,
               $sformatf("fill of %h took %0d addresses", a, arLog.size()));
         for (int i = 0; i < arLog.size(); i++) begin
            check(arLog[i] == base + 16'(2 * i),
                  $sformatf("fill address %0d was %h, base %h", i, arLog[i], base));
         end
      end
   endtask

   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= timeoutCycles) begin
         $display("run stopped after %0d cycles, a fill never finished", cycleCount);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   // AXI memory, settles last cycle's handshakes then drives the next one
   always @(negedge clk) begin
      if (rFired) begin
         readPending = 1'b0;
         rvalid = 1'b0;
      end
      if (arFired) begin
         arLog.push_back(firedAddr);
         pendingAddr = firedAddr;
         readPending = 1'b1;
         arready = 1'b0;
         delaySeed = lcgStep(delaySeed);
         arWait = int'(delaySeed[17:16]);
         delaySeed = lcgStep(delaySeed);
         rWait = int'(delaySeed[17:16]);
      end
      if (arvalid && !arready) begin
         if (arWait == 0) begin
            arready = 1'b1;
         end else begin
            arWait--;
         end
      end
      if (readPending && !rvalid) begin
         if (rWait == 0) begin
            rvalid = 1'b1;
            memRdata = memWord(pendingAddr);
         end else begin
            rWait--;
         end
      end
      // valid and ready now hold until the coming rising edge
      arFired = arvalid && arready;
      rFired = rvalid && rready;
      firedAddr = araddr;
   end

   initial begin
      rstN = 1'b0;
      req = 1'b0;
      addr = '0;
      addrSeed = lcgSeed;
      repeat (2) @(negedge clk);
      rstN = 1'b1;
      #1;

      startTest("reset state");
      check(!arvalid, "arvalid high after reset");
      check(!rready, "rready high after reset");
      check(!ready, "ready high after reset");
      check(arprot == 3'b000, "arprot is not zero");
      access(16'h1234, 1);
      endTest();

      startTest("miss fill");
      access(16'h4a5e, 1);
      endTest();

      startTest("hit");
      for (int i = 0; i < wordsPerBlock; i++) begin
         access(16'h4a50 + 16'(2 * i), 0);
      end
      endTest();

      // tags 1 and 2 share set 5
      startTest("two ways");
      access({6'd1, 6'd5, 4'h0}, 1);
      access({6'd2, 6'd5, 4'h0}, 1);
      for (int i = 0; i < 4; i++) begin
         access({6'd1, 6'd5, 4'h0} + 16'(4 * i), 0);
         access({6'd2, 6'd5, 4'h0} + 16'(4 * i + 2), 0);
      end
      endTest();

      // A and B fill set 9, B is used last so C must push A out
      startTest("LRU replacement");
      access({6'd3, 6'd9, 4'h2}, 1);
      access({6'd4, 6'd9, 4'h4}, 1);
      access({6'd3, 6'd9, 4'h6}, 0);
      access({6'd4, 6'd9, 4'h8}, 0);
      access({6'd5, 6'd9, 4'ha}, 1);
      access({6'd4, 6'd9, 4'hc}, 0);
      access({6'd3, 6'd9, 4'he}, 1);
      endTest();

      // a random read may hit or miss, another word of its block then hits
      startTest("back-pressure random");
      for (int i = 0; i < 10; i++) begin
         addrSeed = lcgStep(addrSeed);
         randAddr = addrSeed[31:16];
         access(randAddr, 2);
         access(randAddr ^ 16'h000e, 0);
      end
      endTest();

      @(negedge clk);
      req = 1'b0;
      repeat (2) @(negedge clk);
      assertFails = cacheTop_inst.cacheTopChk_inst.failCount;
      $display("summary: %0d checks, %0d wrong, %0d assertion failures",
               checkCount, errorCount, assertFails);
      if (errorCount == 0 && assertFails == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: Makefile
SRCS := $(wildcard rtl/*.sv dv/*.sv)

.PHONY: all run clean

all: run

# simulator binary, rebuilt only when a source or the file list changes
obj_dir/VtbCache: list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tbCache

# the log decides the result, a missing pass line fails the target
run: obj_dir/VtbCache
	./obj_dir/VtbCache | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: list.f
rtl/cachePkg.sv
rtl/axiPkg.sv
rtl/fillIf.sv
rtl/beatCounter.sv
rtl/cacheArrays.sv
rtl/fillController.sv
rtl/cacheTop.sv
dv/cacheTop_chk.sv
dv/tbCache.sv
